// ==== verilog/cache_config.svh ====
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// 2 KB direct mapped, 32-byte lines

`define CACHE_ADDR_W  32

`define CACHE_LINES   64
`define CACHE_WORDS   8     // 32-bit words per line

// address split: tag | index | word offset | byte offset
`define CACHE_INDEX_W 6
`define CACHE_WOFS_W  3
`define CACHE_TAG_W   21    // 32 - 6 - 3 - 2

`endif

// ==== verilog/cache_pkg.sv ====
`include "cache_config.svh"

package cache_pkg;

    // data port opcodes, encoding fixed by the core
    typedef enum logic [3:0] {
        LB  = 4'd0,
        LH  = 4'd1,
        LW  = 4'd2,
        LBU = 4'd3,
        LHU = 4'd4,
        SB  = 4'd5,
        SH  = 4'd6,
        SW  = 4'd7
    } mem_op_e;

    typedef enum logic [1:0] {
        IDLE,
        FILL,   // waiting on line read
        WRITE,  // waiting on word write-through
        DONE    // one cycle store grant
    } ctrl_state_e;

    // address fields
    typedef logic [`CACHE_TAG_W-1:0]   tag_t;
    typedef logic [`CACHE_INDEX_W-1:0] index_t;
    typedef logic [`CACHE_WOFS_W-1:0]  word_sel_t;

    // whole line, word 0 in the low bits
    typedef logic [`CACHE_WORDS*32-1:0] line_t;

endpackage

// ==== verilog/line_store_if.sv ====
`timescale 1ns/1ns

interface line_store_if;

    cache_pkg::index_t    index;
    cache_pkg::tag_t      tag;
    cache_pkg::word_sel_t word_sel;

    logic                 wr_en;      // strobed word write
    logic [31:0]          wr_data;
    logic [3:0]           wr_be;

    logic                 fill_en;    // whole line write, sets tag and valid
    cache_pkg::line_t     fill_line;

    logic                 hit;
    logic [31:0]          rd_word;

    modport ctrl (
        output index, tag, word_sel,
        output wr_en, wr_data, wr_be,
        output fill_en, fill_line,
        input  hit, rd_word
    );

    modport store (
        input  index, tag, word_sel,
        input  wr_en, wr_data, wr_be,
        input  fill_en, fill_line,
        output hit, rd_word
    );

endinterface

// ==== verilog/line_store.sv ====
`timescale 1ns/1ns
`include "cache_config.svh"

module line_store (
    input  logic        clk,
    input  logic        reset,
    line_store_if.store bus
);

    cache_pkg::tag_t               tag_mem  [`CACHE_LINES];
    logic [`CACHE_WORDS-1:0][31:0] data_mem [`CACHE_LINES];
    logic [`CACHE_LINES-1:0]       valid;

    logic [31:0] merged_word;

    // lookup is purely combinational off the current address
    assign bus.hit     = valid[bus.index] && (tag_mem[bus.index] == bus.tag);
    assign bus.rd_word = data_mem[bus.index][bus.word_sel];

    // byte merge of store data into the addressed word
    always_comb begin
        merged_word = bus.rd_word;
        for (int b = 0; b < 4; b++) begin
            if (bus.wr_be[b]) begin
                merged_word[b*8 +: 8] = bus.wr_data[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else if (bus.fill_en) begin
            valid[bus.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.fill_en) begin
            tag_mem[bus.index]  <= bus.tag;
            data_mem[bus.index] <= bus.fill_line;
        end else if (bus.wr_en) begin
            // only reached on a hit, tag already matches
            data_mem[bus.index][bus.word_sel] <= merged_word;
        end
    end

endmodule

// ==== verilog/lane_align.sv ====
`timescale 1ns/1ns

module lane_align (
    input  cache_pkg::mem_op_e op,
    input  logic [1:0]         byte_ofs,
    input  logic [31:0]        rd_word,
    input  logic [31:0]        cpu_wdata,
    output logic [31:0]        load_data,
    output logic [31:0]        store_data,
    output logic [3:0]         store_be
);

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    always_comb begin
        case (byte_ofs)
            2'd0:    byte_lane = rd_word[7:0];
            2'd1:    byte_lane = rd_word[15:8];
            2'd2:    byte_lane = rd_word[23:16];
            default: byte_lane = rd_word[31:24];
        endcase
    end

    // odd offsets fall back to the lower halfword of their half
    assign half_lane = byte_ofs[1] ? rd_word[31:16] : rd_word[15:0];

    always_comb begin
        case (op)
            cache_pkg::LB:  load_data = {{24{byte_lane[7]}}, byte_lane};
            cache_pkg::LBU: load_data = {24'b0, byte_lane};
            cache_pkg::LH:  load_data = {{16{half_lane[15]}}, half_lane};
            cache_pkg::LHU: load_data = {16'b0, half_lane};
            default:        load_data = rd_word;    // LW
        endcase
    end

    // stores replicate into every lane, strobes pick the live bytes
    always_comb begin
        store_data = cpu_wdata;
        store_be   = 4'b0000;
        case (op)
            cache_pkg::SB: begin
                store_data = {4{cpu_wdata[7:0]}};
                store_be   = 4'b0001 << byte_ofs;
            end
            cache_pkg::SH: begin
                store_data = {2{cpu_wdata[15:0]}};
                store_be   = byte_ofs[1] ? 4'b1100 : 4'b0011;
            end
            cache_pkg::SW: begin
                store_be = 4'b1111;
            end
            default: ;  // loads and unknown ops write nothing
        endcase
    end

endmodule

// ==== verilog/cache_ctrl.sv ====
`timescale 1ns/1ns
`include "cache_config.svh"

module cache_ctrl (
    input  logic                     clk,
    input  logic                     reset,

    // processor side
    input  logic                     data_req,
    input  cache_pkg::mem_op_e       data_op,
    input  logic [`CACHE_ADDR_W-1:0] cpu_addr,
    output logic                     data_gnt,
    output logic                     data_rvalid,
    output logic [31:0]              cpu_rdata,

    // memory side
    output logic [`CACHE_ADDR_W-1:0] mem_addr,
    output logic                     mem_read,
    output logic                     mem_write,
    output logic [31:0]              mem_wdata,
    output logic [3:0]               mem_be,
    input  cache_pkg::line_t         mem_rdata,
    input  logic                     mem_ready,

    // from lane_align
    input  logic [31:0]              load_data,
    input  logic [31:0]              store_data,
    input  logic [3:0]               store_be,

    line_store_if.ctrl               bus
);

    localparam int OFS_W = `CACHE_WOFS_W + 2;  // word plus byte offset bits

    cache_pkg::ctrl_state_e state;
    cache_pkg::ctrl_state_e next_state;

    logic is_load;
    logic is_store;

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        case (data_op)
            cache_pkg::LB,
            cache_pkg::LH,
            cache_pkg::LW,
            cache_pkg::LBU,
            cache_pkg::LHU: is_load = 1'b1;
            cache_pkg::SB,
            cache_pkg::SH,
            cache_pkg::SW:  is_store = 1'b1;
            default: ;
        endcase
    end

    // address split, request is held stable until grant
    assign bus.tag      = cpu_addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign bus.index    = cpu_addr[OFS_W +: `CACHE_INDEX_W];
    assign bus.word_sel = cpu_addr[2 +: `CACHE_WOFS_W];

    assign bus.wr_data   = store_data;
    assign bus.wr_be     = store_be;
    assign bus.fill_line = mem_rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cache_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state  = state;
        data_gnt    = 1'b0;
        data_rvalid = 1'b0;
        bus.wr_en   = 1'b0;
        bus.fill_en = 1'b0;

        case (state)
            cache_pkg::IDLE: begin
                if (data_req) begin
                    if (is_load) begin
                        if (bus.hit) begin
                            data_gnt    = 1'b1;   // zero cycle load hit
                            data_rvalid = 1'b1;
                        end else begin
                            next_state = cache_pkg::FILL;
                        end
                    end else if (is_store) begin
                        // write-through; a miss leaves the line alone
                        bus.wr_en  = bus.hit;
                        next_state = cache_pkg::WRITE;
                    end else begin
                        data_gnt = 1'b1;  // unknown op, no effect
                    end
                end
            end

            cache_pkg::FILL: begin
                if (mem_ready) begin
                    bus.fill_en = 1'b1;
                    next_state  = cache_pkg::IDLE;  // replays as a hit
                end
            end

            cache_pkg::WRITE: begin
                if (mem_ready) begin
                    next_state = cache_pkg::DONE;
                end
            end

            cache_pkg::DONE: begin
                data_gnt   = 1'b1;
                next_state = cache_pkg::IDLE;
            end

            default: next_state = cache_pkg::IDLE;
        endcase
    end

    // memory handshake straight off the state register
    assign mem_read  = (state == cache_pkg::FILL);
    assign mem_write = (state == cache_pkg::WRITE);

    // block aligned for a fill, word aligned for a write
    assign mem_addr = mem_read ? {cpu_addr[`CACHE_ADDR_W-1:OFS_W], {OFS_W{1'b0}}}
                               : {cpu_addr[`CACHE_ADDR_W-1:2], 2'b00};

    assign mem_wdata = store_data;
    assign mem_be    = mem_write ? store_be : 4'b0000;

    assign cpu_rdata = load_data;

endmodule

// ==== verilog/cache_top.sv ====
`timescale 1ns/1ns
`include "cache_config.svh"

module cache_top (
    input  logic                     clk,
    input  logic                     reset,

    // processor data port
    input  logic                     data_req,
    input  logic [3:0]               data_op,
    input  logic [`CACHE_ADDR_W-1:0] cpu_addr,
    input  logic [31:0]              cpu_wdata,
    output logic                     data_gnt,
    output logic                     data_rvalid,
    output logic [31:0]              cpu_rdata,

    // backing memory
    output logic [`CACHE_ADDR_W-1:0] mem_addr,
    output logic                     mem_read,
    output logic                     mem_write,
    output logic [31:0]              mem_wdata,
    output logic [3:0]               mem_be,
    input  cache_pkg::line_t         mem_rdata,
    input  logic                     mem_ready
);

    cache_pkg::mem_op_e op;

    logic [31:0] load_data;
    logic [31:0] store_data;
    logic [3:0]  store_be;

    assign op = cache_pkg::mem_op_e'(data_op);

    line_store_if ls_bus ();

    cache_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .data_req    (data_req),
        .data_op     (op),
        .cpu_addr    (cpu_addr),
        .data_gnt    (data_gnt),
        .data_rvalid (data_rvalid),
        .cpu_rdata   (cpu_rdata),
        .mem_addr    (mem_addr),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_wdata   (mem_wdata),
        .mem_be      (mem_be),
        .mem_rdata   (mem_rdata),
        .mem_ready   (mem_ready),
        .load_data   (load_data),
        .store_data  (store_data),
        .store_be    (store_be),
        .bus         (ls_bus.ctrl)
    );

    line_store u_store (
        .clk   (clk),
        .reset (reset),
        .bus   (ls_bus.store)
    );

    lane_align u_align (
        .op         (op),
        .byte_ofs   (cpu_addr[1:0]),
        .rd_word    (ls_bus.rd_word),
        .cpu_wdata  (cpu_wdata),
        .load_data  (load_data),
        .store_data (store_data),
        .store_be   (store_be)
    );

endmodule

// ==== test/mem_model.sv ====
`timescale 1ns/1ns

module mem_model (
    input  logic             clk,
    input  logic             reset,
    input  logic [31:0]      mem_addr,
    input  logic             mem_read,
    input  logic             mem_write,
    input  logic [31:0]      mem_wdata,
    input  logic [3:0]       mem_be,
    output cache_pkg::line_t mem_rdata,
    output logic             mem_ready
);

    logic [31:0] mem [1024];        // 4 KB
    logic [1:0]  delay_tab [256];
    logic [7:0]  delay_ptr;
    logic [1:0]  wait_cnt;
    logic [9:0]  word_idx;

    initial begin
        logic [31:0] a;
        logic [31:0] r;
        void'($urandom(82));
        for (int i = 0; i < 1024; i++) begin
            a = i * 4;
            mem[i] = {~a[31:16], a[15:0]};  // byte address, upper half inverted
        end
        for (int i = 0; i < 256; i++) begin
            r = $urandom;
            delay_tab[i] = r[1:0];
        end
    end

    assign word_idx  = mem_addr[11:2];
    assign mem_ready = (mem_read || mem_write) && (wait_cnt == 2'd0);

    // whole line around the addressed word
    always_comb begin
        for (int w = 0; w < 8; w++) begin
            mem_rdata[w*32 +: 32] = mem[{word_idx[9:3], w[2:0]}];
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            wait_cnt  <= delay_tab[0];
            delay_ptr <= 8'd1;
        end else if (mem_read || mem_write) begin
            if (wait_cnt == 2'd0) begin
                if (mem_write) begin
                    for (int b = 0; b < 4; b++) begin
                        if (mem_be[b]) begin
                            mem[word_idx][b*8 +: 8] <= mem_wdata[b*8 +: 8];
                        end
                    end
                end
                wait_cnt  <= delay_tab[delay_ptr];  // delay for the next transfer
                delay_ptr <= delay_ptr + 8'd1;
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

endmodule

// ==== test/cache_tb.sv ====
`timescale 1ns/1ns

module cache_tb;

    localparam int TIMEOUT_CYCLES = 100;

    typedef struct packed {
        cache_pkg::mem_op_e op;
        logic [31:0]        addr;
        logic [31:0]        wdata;
        logic [31:0]        exp_data;   // load result, or memory word after a store
        logic               exp_fill;
    } row_t;

    logic             clk;
    logic             reset;
    logic             data_req;
    logic [3:0]       data_op;
    logic [31:0]      cpu_addr;
    logic [31:0]      cpu_wdata;
    logic             data_gnt;
    logic             data_rvalid;
    logic [31:0]      cpu_rdata;
    logic [31:0]      mem_addr;
    logic             mem_read;
    logic             mem_write;
    logic [31:0]      mem_wdata;
    logic [3:0]       mem_be;
    cache_pkg::line_t mem_rdata;
    logic             mem_ready;

    logic [31:0] shadow [1024];     // expected backing memory
    row_t        rows [$];
    int          data_errors;
    int          fill_errors;
    int          mem_errors;
    int          bus_errors;
    int          timeouts;

    cache_top u_cache_top (.*);
    mem_model u_mem (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] load_value(cache_pkg::mem_op_e op, logic [31:0] w,
                                               logic [1:0] ofs);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[8*ofs +: 8];
        h = w[16*ofs[1] +: 16];     // odd offsets stay in their half
        case (op)
            cache_pkg::LB:  return {{24{b[7]}}, b};
            cache_pkg::LBU: return {24'd0, b};
            cache_pkg::LH:  return {{16{h[15]}}, h};
            cache_pkg::LHU: return {16'd0, h};
            default:        return w;
        endcase
    endfunction

    function automatic logic [31:0] merge_store(cache_pkg::mem_op_e op, logic [31:0] old,
                                                logic [31:0] wdata, logic [1:0] ofs);
        logic [31:0] w;
        w = old;
        case (op)
            cache_pkg::SB: w[8*ofs +: 8] = wdata[7:0];
            cache_pkg::SH: w[16*ofs[1] +: 16] = wdata[15:0];
            cache_pkg::SW: w = wdata;
            default: ;
        endcase
        return w;
    endfunction

    function automatic void add_row(cache_pkg::mem_op_e op, logic [31:0] addr,
                                    logic [31:0] wdata, logic fill);
        row_t r;
        r.op       = op;
        r.addr     = addr;
        r.wdata    = wdata;
        r.exp_fill = fill;
        if (op == cache_pkg::SB || op == cache_pkg::SH || op == cache_pkg::SW) begin
            shadow[addr[11:2]] = merge_store(op, shadow[addr[11:2]], wdata, addr[1:0]);
            r.exp_data = shadow[addr[11:2]];
        end else begin
            r.exp_data = load_value(op, shadow[addr[11:2]], addr[1:0]);
        end
        rows.push_back(r);
    endfunction

    function automatic void build_table();
        logic [31:0] a;
        for (int i = 0; i < 1024; i++) begin
            a = i * 4;
            shadow[i] = {~a[31:16], a[15:0]};
        end
        add_row(cache_pkg::LW, 32'h040, 32'd0, 1'b1);  // cold miss
        add_row(cache_pkg::LW, 32'h05c, 32'd0, 1'b0);
        // word 0xffff0044 has both sign polarities
        for (int o = 0; o < 4; o++) begin
            add_row(cache_pkg::LB,  32'h044 + o, 32'd0, 1'b0);
            add_row(cache_pkg::LBU, 32'h044 + o, 32'd0, 1'b0);
            add_row(cache_pkg::LH,  32'h044 + o, 32'd0, 1'b0);
            add_row(cache_pkg::LHU, 32'h044 + o, 32'd0, 1'b0);
        end
        add_row(cache_pkg::SB,  32'h049, 32'h0000_00a5, 1'b0);
        add_row(cache_pkg::LW,  32'h048, 32'd0, 1'b0);
        add_row(cache_pkg::LB,  32'h049, 32'd0, 1'b0);
        add_row(cache_pkg::SH,  32'h04e, 32'h0000_8123, 1'b0);
        add_row(cache_pkg::LW,  32'h04c, 32'd0, 1'b0);
        add_row(cache_pkg::SH,  32'h053, 32'h0000_7e55, 1'b0);
        add_row(cache_pkg::LHU, 32'h052, 32'd0, 1'b0);
        // store miss, line stays out until a load
        add_row(cache_pkg::SW,  32'h300, 32'hdead_beef, 1'b0);
        add_row(cache_pkg::LW,  32'h300, 32'd0, 1'b1);
        add_row(cache_pkg::LBU, 32'h302, 32'd0, 1'b0);
        // 0x100 and 0x900 share index 8
        add_row(cache_pkg::LW,  32'h100, 32'd0, 1'b1);
        add_row(cache_pkg::LW,  32'h900, 32'd0, 1'b1);
        add_row(cache_pkg::LW,  32'h104, 32'd0, 1'b1);
        add_row(cache_pkg::LW,  32'h904, 32'd0, 1'b1);
        add_row(cache_pkg::SW,  32'h908, 32'h1357_9bdf, 1'b0);
        add_row(cache_pkg::LW,  32'h108, 32'd0, 1'b1);
        add_row(cache_pkg::LW,  32'h908, 32'd0, 1'b1);
    endfunction

    task automatic apply_row(int n, output bit ok);
        row_t        r;
        int          cycles;
        int          fills;
        int          writes;
        int          xfer_cycle;
        bit          granted;
        bit          store;
        logic [31:0] got_data;
        logic        got_valid;
        logic [31:0] exp_addr;
        r          = rows[n];
        store      = (r.op == cache_pkg::SB || r.op == cache_pkg::SH || r.op == cache_pkg::SW);
        cycles     = 0;
        fills      = 0;
        writes     = 0;
        xfer_cycle = 0;
        granted    = 1'b0;
        got_data   = 32'd0;
        got_valid  = 1'b0;
        @(posedge clk);
        data_req  <= 1'b1;
        data_op   <= r.op;
        cpu_addr  <= r.addr;
        cpu_wdata <= r.wdata;
        while (!granted && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);     // outputs settled here
            cycles++;
            // line address on a fill, word address on a write
            exp_addr = mem_read ? {r.addr[31:5], 5'd0} : {r.addr[31:2], 2'd0};
            if ((mem_read || mem_write) && mem_addr != exp_addr) begin
                $display("** Error at %0t ns: row %0d %s mem_addr %h expected %h",
                         $time, n, r.op.name(), mem_addr, exp_addr);
                bus_errors++;
            end
            if (mem_read && mem_ready) begin
                fills++;
                xfer_cycle = cycles;
            end
            if (mem_write && mem_ready) begin
                writes++;
                xfer_cycle = cycles;
            end
            if (data_gnt) begin
                granted   = 1'b1;
                got_data  = cpu_rdata;
                got_valid = data_rvalid;
            end
        end
        ok = granted;
        if (!granted) begin
            $display("row %0d (%s) got no grant within %0d cycles", n, r.op.name(),
                     TIMEOUT_CYCLES);
            timeouts++;
        end else begin
            if (fills != int'(r.exp_fill) || writes != int'(store)) begin
                $display("** Error at %0t ns: row %0d %s fills %0d writes %0d expected %0d %0d",
                         $time, n, r.op.name(), fills, writes, r.exp_fill, store);
                fill_errors++;
            end
            // grant one cycle after the last transfer, or at once on a hit
            if (cycles != xfer_cycle + 1) begin
                $display("** Error at %0t ns: row %0d %s granted in cycle %0d expected %0d",
                         $time, n, r.op.name(), cycles, xfer_cycle + 1);
                bus_errors++;
            end
            if (!store && (!got_valid || got_data != r.exp_data)) begin
                $display("** Error at %0t ns: row %0d %s addr %h rdata %h rvalid %b expected %h",
                         $time, n, r.op.name(), r.addr, got_data, got_valid, r.exp_data);
                data_errors++;
            end
            if (store && got_valid) begin
                $display("** Error at %0t ns: row %0d %s rvalid high on store grant",
                         $time, n, r.op.name());
                data_errors++;
            end
            if (store && u_mem.mem[r.addr[11:2]] != r.exp_data) begin
                $display("** Error at %0t ns: row %0d %s memory word %h expected %h",
                         $time, n, r.op.name(), u_mem.mem[r.addr[11:2]], r.exp_data);
                mem_errors++;
            end
        end
    endtask

    initial begin
        bit ok;
        clk         = 1'b0;
        reset       = 1'b1;
        data_req    = 1'b0;
        data_op     = 4'd0;
        cpu_addr    = 32'd0;
        cpu_wdata   = 32'd0;
        data_errors = 0;
        fill_errors = 0;
        mem_errors  = 0;
        bus_errors  = 0;
        timeouts    = 0;
        build_table();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (data_gnt || data_rvalid || mem_read || mem_write) begin
            $display("** Error at %0t ns: handshake outputs not low after reset", $time);
            data_errors++;
        end
        ok = 1'b1;
        for (int n = 0; n < rows.size() && ok; n++) begin
            apply_row(n, ok);
        end
        @(posedge clk);
        data_req <= 1'b0;
        $display("rows %0d, errors data %0d fill %0d memory %0d bus %0d, timeouts %0d",
                 rows.size(), data_errors, fill_errors, mem_errors, bus_errors, timeouts);
        if (data_errors + fill_errors + mem_errors + bus_errors + timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+verilog
verilog/cache_pkg.sv
verilog/line_store_if.sv
verilog/line_store.sv
verilog/lane_align.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
test/mem_model.sv
test/cache_tb.sv

// ==== Makefile ====
# Verilator build and run of the cache testbench

TOP = cache_tb

all: run

run:
	verilator --binary --timing --timescale 1ns/1ns -f project.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

lint:
	verilator --lint-only --timing --timescale 1ns/1ns -Wall -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
